//--- hdl/ram_bus_pkg.sv
// RAM bus definitions
// Widths and vector types of the main RAM write port that the
// status monitor snoops

package ram_bus_pkg;

  // Byte address as seen by software
  parameter int ByteAw = 32;

  // Byte lane select bits below the word address
  parameter int ByteOffW = 2;

  // 64 KiB RAM word addressed by byte address bits 15:2
  parameter int RamAw = 14;

  // Write data width
  parameter int RamDw = 32;

  // Word address on the RAM port
  typedef logic [RamAw-1:0] ram_word_addr_t;

  // One write data word
  typedef logic [RamDw-1:0] ram_data_t;

  // Full byte address, used for the configured status and log locations
  typedef logic [ByteAw-1:0] byte_addr_t;

endpackage

//--- hdl/sw_status_pkg.sv
// Software status definitions
// Status codes that software writes to the status word, and the
// test state the monitor derives from them

package sw_status_pkg;

  // Codes written by software to the status word
  // Boot ROM has started
  parameter ram_bus_pkg::ram_data_t StatusInBootRom = 32'h0000b090;

  // Test code is running
  parameter ram_bus_pkg::ram_data_t StatusInTest = 32'h00004354;

  // Test finished successfully
  parameter ram_bus_pkg::ram_data_t StatusPassed = 32'h0000900d;

  // Test finished with a failure
  parameter ram_bus_pkg::ram_data_t StatusFailed = 32'h0000baad;

  // Test state as decoded from the status writes
  // StPassed and StFailed are final until reset
  typedef enum logic [2:0] {
    StIdle      = 3'd0,
    StInBootRom = 3'd1,
    StInTest    = 3'd2,
    StPassed    = 3'd3,
    StFailed    = 3'd4
  } test_state_e;

endpackage

//--- hdl/ram_write_snoop.sv
// RAM write snoop
// Registers writes on the main RAM port and flags the ones that hit
// the status word or the log word

module ram_write_snoop #(
  parameter ram_bus_pkg::byte_addr_t StatusAddr = 32'h0000fff8,
  parameter ram_bus_pkg::byte_addr_t LogAddr    = 32'h0000fffc
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  // Nothing is snooped while the CPU is stubbed
  input  logic                       stub_cpu_i,

  // Main RAM port
  input  logic                       req_i,
  input  logic                       write_i,
  input  ram_bus_pkg::ram_word_addr_t addr_i,
  input  ram_bus_pkg::ram_data_t      wdata_i,

  // One cycle hit pulses and the matching data word
  output logic                       status_hit_o,
  output logic                       log_hit_o,
  output ram_bus_pkg::ram_data_t      data_o
);

  // RAM only decodes the word address, so drop the byte lane bits
  localparam ram_bus_pkg::ram_word_addr_t StatusWordAddr =
      StatusAddr[ram_bus_pkg::RamAw+ram_bus_pkg::ByteOffW-1:ram_bus_pkg::ByteOffW];
  localparam ram_bus_pkg::ram_word_addr_t LogWordAddr =
      LogAddr[ram_bus_pkg::RamAw+ram_bus_pkg::ByteOffW-1:ram_bus_pkg::ByteOffW];

  logic write_seen;
  logic status_match;
  logic log_match;

  // A write the monitor is allowed to see
  assign write_seen = req_i && write_i && !stub_cpu_i;

  assign status_match = write_seen && (addr_i == StatusWordAddr);
  assign log_match    = write_seen && (addr_i == LogWordAddr);

  // Hit pulses
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      status_hit_o <= 1'b0;
      log_hit_o    <= 1'b0;
    end else begin
      status_hit_o <= status_match;
      log_hit_o    <= log_match;
    end
  end

  // Data word of the last snooped write
  always_ff @(posedge clk_i) begin
    if (write_seen) begin
      data_o <= wdata_i;
    end
  end

endmodule

//--- hdl/test_status_decoder.sv
// Test status decoder
// FSM that follows the status codes written by software and holds
// the final pass or fail result until reset

module test_status_decoder (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  // Status word write from the snoop stage
  input  logic                       status_hit_i,
  input  ram_bus_pkg::ram_data_t      data_i,

  // Decoded test state and result
  output sw_status_pkg::test_state_e  test_state_o,
  output logic                       test_done_o,
  output logic                       test_passed_o
);

  sw_status_pkg::test_state_e state_q;
  sw_status_pkg::test_state_e state_d;
  logic                       locked;

  // Final states ignore any further status writes
  assign locked = (state_q == sw_status_pkg::StPassed) ||
                  (state_q == sw_status_pkg::StFailed);

  always_comb begin
    state_d = state_q;
    if (status_hit_i && !locked) begin
      case (data_i)
        sw_status_pkg::StatusInBootRom: begin
          state_d = sw_status_pkg::StInBootRom;
        end
        sw_status_pkg::StatusInTest: begin
          state_d = sw_status_pkg::StInTest;
        end
        sw_status_pkg::StatusPassed: begin
          state_d = sw_status_pkg::StPassed;
        end
        sw_status_pkg::StatusFailed: begin
          state_d = sw_status_pkg::StFailed;
        end
        // Unknown codes leave the state as it is
        default: begin
          state_d = state_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= sw_status_pkg::StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Outputs follow the state register directly
  assign test_state_o  = state_q;
  assign test_done_o   = locked;
  assign test_passed_o = (state_q == sw_status_pkg::StPassed);

endmodule

//--- hdl/sw_log_fifo.sv
// Software log FIFO
// Show-ahead circular buffer of log words written by software, with a
// sticky flag for words lost while full

module sw_log_fifo #(
  parameter int LogDepth = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Write side from the snoop stage
  input  logic                  push_i,
  input  ram_bus_pkg::ram_data_t push_data_i,

  // Read side with the oldest word always shown
  input  logic                  pop_i,
  output logic                  valid_o,
  output ram_bus_pkg::ram_data_t data_o,

  // Set when a push is dropped and held until reset
  output logic                  overflow_o
);

  localparam int PtrW = $clog2(LogDepth);
  localparam int CntW = $clog2(LogDepth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  ram_bus_pkg::ram_data_t mem [LogDepth];

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;

  logic full;
  logic empty;
  logic pop_ok;
  logic push_ok;

  assign empty = (count == '0);
  assign full  = (count == cnt_t'(LogDepth));

  // Pop of an empty FIFO is ignored
  assign pop_ok = pop_i && !empty;

  // A full FIFO still accepts a push when a word leaves on the same edge
  assign push_ok = push_i && (!full || pop_ok);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Occupancy
      if (push_ok && !pop_ok) begin
        count <= count + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count <= count - 1'b1;
      end
      // Word lost
      if (push_i && !push_ok) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  assign valid_o = !empty;
  assign data_o  = mem[rd_ptr];

endmodule

//--- hdl/sw_status_monitor.sv
// Software status monitor
// Snoops main RAM writes and turns status writes into a test state
// and log writes into a readable log FIFO

module sw_status_monitor #(
  parameter ram_bus_pkg::byte_addr_t StatusAddr = 32'h0000fff8,
  parameter ram_bus_pkg::byte_addr_t LogAddr    = 32'h0000fffc,
  parameter int                      LogDepth   = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       stub_cpu_i,

  // Main RAM write port
  input  logic                       req_i,
  input  logic                       write_i,
  input  ram_bus_pkg::ram_word_addr_t addr_i,
  input  ram_bus_pkg::ram_data_t      wdata_i,

  // Test status
  output sw_status_pkg::test_state_e  test_state_o,
  output logic                       test_done_o,
  output logic                       test_passed_o,

  // Log reader
  input  logic                       log_pop_i,
  output logic                       log_valid_o,
  output ram_bus_pkg::ram_data_t      log_data_o,
  output logic                       log_overflow_o
);

  logic                   status_hit;
  logic                   log_hit;
  ram_bus_pkg::ram_data_t snoop_data;

  ram_write_snoop #(
    .StatusAddr (StatusAddr),
    .LogAddr    (LogAddr)
  ) u_ram_write_snoop (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .stub_cpu_i   (stub_cpu_i),
    .req_i        (req_i),
    .write_i      (write_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .status_hit_o (status_hit),
    .log_hit_o    (log_hit),
    .data_o       (snoop_data)
  );

  test_status_decoder u_test_status_decoder (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .status_hit_i  (status_hit),
    .data_i        (snoop_data),
    .test_state_o  (test_state_o),
    .test_done_o   (test_done_o),
    .test_passed_o (test_passed_o)
  );

  sw_log_fifo #(
    .LogDepth (LogDepth)
  ) u_sw_log_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (log_hit),
    .push_data_i (snoop_data),
    .pop_i       (log_pop_i),
    .valid_o     (log_valid_o),
    .data_o      (log_data_o),
    .overflow_o  (log_overflow_o)
  );

endmodule

//--- sim/sw_status_monitor_checker.sv
// Assertion checker for the software status monitor
// Bound into the DUT top to watch the result and log flags

module sw_status_monitor_checker (
  input logic clk_i,
  input logic rst_n_i,
  input logic test_done_i,
  input logic test_passed_i,
  input logic log_valid_i,
  input logic log_overflow_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed assertions
  int fail_count = 0;

  // Final result holds until reset
  done_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    test_done_i |=> test_done_i)
    else begin
      fail_count++;
      $error("test_done_o fell without a reset");
    end

  overflow_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    log_overflow_i |=> log_overflow_i)
    else begin
      fail_count++;
      $error("log_overflow_o fell without a reset");
    end

  passed_means_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    test_passed_i |-> test_done_i)
    else begin
      fail_count++;
      $error("test_passed_o high while test_done_o is low");
    end

  // Log starts empty
  empty_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !log_valid_i)
    else begin
      fail_count++;
      $error("log_valid_o high right after reset release");
    end

endmodule

//--- sim/sw_status_scoreboard.sv
// Scoreboard for the software status monitor
// Reference model of the status decoding and the log FIFO, compared
// with the DUT outputs on every falling clock edge

module sw_status_scoreboard #(
  parameter ram_bus_pkg::byte_addr_t StatusAddr = 32'h0000fff8,
  parameter ram_bus_pkg::byte_addr_t LogAddr    = 32'h0000fffc,
  parameter int                      LogDepth   = 8,
  parameter int                      NameW      = 128
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        stub_cpu_i,
  input  logic                        req_i,
  input  logic                        write_i,
  input  ram_bus_pkg::ram_word_addr_t addr_i,
  input  ram_bus_pkg::ram_data_t      wdata_i,
  input  logic                        log_pop_i,
  input  sw_status_pkg::test_state_e  test_state_i,
  input  logic                        test_done_i,
  input  logic                        test_passed_i,
  input  logic                        log_valid_i,
  input  ram_bus_pkg::ram_data_t      log_data_i,
  input  logic                        log_overflow_i,
  input  logic [NameW-1:0]            test_name_i,
  output int                          error_count_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Software byte address bits 15:2 select the RAM word
  localparam ram_bus_pkg::ram_word_addr_t StatusWord =
      ram_bus_pkg::ram_word_addr_t'(StatusAddr >> 2);
  localparam ram_bus_pkg::ram_word_addr_t LogWord =
      ram_bus_pkg::ram_word_addr_t'(LogAddr >> 2);

  sw_status_pkg::test_state_e exp_state = sw_status_pkg::StIdle;
  ram_bus_pkg::ram_data_t     exp_log[$];
  logic                       exp_overflow = 1'b0;
  logic                       status_pend = 1'b0;
  logic                       log_pend = 1'b0;
  ram_bus_pkg::ram_data_t     pend_data = '0;
  logic [NameW-1:0]           name_q1;
  logic [NameW-1:0]           name_q2;
  int                         errors = 0;

  assign error_count_o = errors;

  // Pass and fail are final and unknown codes leave the state alone
  function automatic sw_status_pkg::test_state_e next_state(
    input sw_status_pkg::test_state_e cur,
    input ram_bus_pkg::ram_data_t     code
  );
    if (cur == sw_status_pkg::StPassed || cur == sw_status_pkg::StFailed) begin
      return cur;
    end
    case (code)
      sw_status_pkg::StatusInBootRom: return sw_status_pkg::StInBootRom;
      sw_status_pkg::StatusInTest:    return sw_status_pkg::StInTest;
      sw_status_pkg::StatusPassed:    return sw_status_pkg::StPassed;
      sw_status_pkg::StatusFailed:    return sw_status_pkg::StFailed;
      default:                        return cur;
    endcase
  endfunction

  task automatic check_field(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Fail %0s %0s: expected %h, actual %h", name_q2, field, exp, act);
    end
  endtask

  // Writes seen at one edge take effect in the model at the next
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exp_state    = sw_status_pkg::StIdle;
      exp_log.delete();
      exp_overflow = 1'b0;
      status_pend  = 1'b0;
      log_pend     = 1'b0;
    end else begin
      if (status_pend) begin
        exp_state = next_state(exp_state, pend_data);
      end
      // Pop first, so a full log still takes a word on the same edge
      if (log_pop_i && exp_log.size() != 0) begin
        void'(exp_log.pop_front());
      end
      if (log_pend) begin
        if (exp_log.size() < LogDepth) begin
          exp_log.push_back(pend_data);
        end else begin
          exp_overflow = 1'b1;
        end
      end
      status_pend = req_i && write_i && !stub_cpu_i && (addr_i == StatusWord);
      log_pend    = req_i && write_i && !stub_cpu_i && (addr_i == LogWord);
      pend_data   = wdata_i;
    end
  end

  // Name of the step whose effects are visible two edges later
  always @(posedge clk_i) begin
    name_q1 <= test_name_i;
    name_q2 <= name_q1;
  end

  always @(negedge clk_i) begin
    logic exp_done;
    exp_done = (exp_state == sw_status_pkg::StPassed) ||
               (exp_state == sw_status_pkg::StFailed);
    if (rst_n_i) begin
      check_field("test_state", 32'(exp_state), 32'(test_state_i));
      check_field("test_done", 32'(exp_done), 32'(test_done_i));
      check_field("test_passed", 32'(exp_state == sw_status_pkg::StPassed),
                  32'(test_passed_i));
      check_field("log_valid", 32'(exp_log.size() != 0), 32'(log_valid_i));
      check_field("log_overflow", 32'(exp_overflow), 32'(log_overflow_i));
      if (exp_log.size() != 0) begin
        check_field("log_data", exp_log[0], log_data_i);
      end
    end
  end

endmodule

//--- sim/sw_status_monitor_tb.sv
// Testbench for the software status monitor
// Applies a table of RAM writes and log pops while the scoreboard
// checks the status and log outputs

module sw_status_monitor_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam ram_bus_pkg::byte_addr_t StatusAddr = 32'h0000fff8;
  localparam ram_bus_pkg::byte_addr_t LogAddr    = 32'h0000fffc;
  localparam int LogDepth    = 4;
  localparam int NameW       = 128;
  localparam int ResetCycles = 3;

  // One table entry is applied for one clock cycle
  typedef struct {
    logic [NameW-1:0]        name;
    bit                      rst;
    bit                      stub;
    bit                      req;
    bit                      wr;
    ram_bus_pkg::byte_addr_t addr;
    ram_bus_pkg::ram_data_t  data;
    bit                      pop;
  } step_t;

  step_t steps[$];

  logic                        clk;
  logic                        rst_n;
  logic                        stub_cpu;
  logic                        req;
  logic                        wr;
  ram_bus_pkg::ram_word_addr_t addr;
  ram_bus_pkg::ram_data_t      wdata;
  logic                        log_pop;
  sw_status_pkg::test_state_e  test_state;
  logic                        test_done;
  logic                        test_passed;
  logic                        log_valid;
  ram_bus_pkg::ram_data_t      log_data;
  logic                        log_overflow;
  logic [NameW-1:0]            cur_name;
  int                          error_count;
  int                          total_errors;
  int                          cycle_count = 0;
  int                          cycle_limit = 0;
  logic [31:0]                 lfsr = 32'hae034871;

  sw_status_monitor #(
    .StatusAddr (StatusAddr),
    .LogAddr    (LogAddr),
    .LogDepth   (LogDepth)
  ) u_sw_status_monitor (
    .clk_i (clk), .rst_n_i (rst_n), .stub_cpu_i (stub_cpu),
    .req_i (req), .write_i (wr), .addr_i (addr), .wdata_i (wdata),
    .test_state_o (test_state), .test_done_o (test_done), .test_passed_o (test_passed),
    .log_pop_i (log_pop), .log_valid_o (log_valid), .log_data_o (log_data),
    .log_overflow_o (log_overflow)
  );

  sw_status_scoreboard #(
    .StatusAddr (StatusAddr),
    .LogAddr    (LogAddr),
    .LogDepth   (LogDepth),
    .NameW      (NameW)
  ) u_scoreboard (
    .clk_i (clk), .rst_n_i (rst_n), .stub_cpu_i (stub_cpu),
    .req_i (req), .write_i (wr), .addr_i (addr), .wdata_i (wdata),
    .log_pop_i (log_pop), .test_state_i (test_state), .test_done_i (test_done),
    .test_passed_i (test_passed), .log_valid_i (log_valid), .log_data_i (log_data),
    .log_overflow_i (log_overflow), .test_name_i (cur_name),
    .error_count_o (error_count)
  );

  bind sw_status_monitor sw_status_monitor_checker u_checker (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .test_done_i (test_done_o),
    .test_passed_i (test_passed_o), .log_valid_i (log_valid_o),
    .log_overflow_i (log_overflow_o)
  );

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic ram_bus_pkg::byte_addr_t random_other_addr();
    ram_bus_pkg::ram_word_addr_t word;
    ram_bus_pkg::byte_addr_t     addr_b;
    word = ram_bus_pkg::ram_word_addr_t'(random_bits(ram_bus_pkg::RamAw));
    addr_b = {16'h0000, word, 2'b00};
    // Keep clear of both snooped words
    if (addr_b == StatusAddr || addr_b == LogAddr) begin
      addr_b = addr_b ^ 32'h0000_0100;
    end
    return addr_b;
  endfunction

  task automatic add_step(input logic [NameW-1:0] name, input bit rst, input bit stub,
                          input bit rq, input bit w, input ram_bus_pkg::byte_addr_t a,
                          input ram_bus_pkg::ram_data_t d, input bit p);
    step_t s;
    s.name = name;
    s.rst  = rst;
    s.stub = stub;
    s.req  = rq;
    s.wr   = w;
    s.addr = a;
    s.data = d;
    s.pop  = p;
    steps.push_back(s);
  endtask

  task automatic build_table();
    add_step("idle_0", 0, 0, 0, 0, '0, '0, 0);
    add_step("idle_1", 0, 0, 0, 0, '0, '0, 0);
    add_step("boot_rom", 0, 0, 1, 1, StatusAddr, sw_status_pkg::StatusInBootRom, 0);
    add_step("in_test", 0, 0, 1, 1, StatusAddr, sw_status_pkg::StatusInTest, 0);
    add_step("bad_code", 0, 0, 1, 1, StatusAddr, 32'h0000beef, 0);
    add_step("status_read", 0, 0, 1, 0, StatusAddr, sw_status_pkg::StatusPassed, 0);
    add_step("no_req", 0, 0, 0, 1, StatusAddr, sw_status_pkg::StatusPassed, 0);
    add_step("other_addr", 0, 0, 1, 1, random_other_addr(), sw_status_pkg::StatusPassed, 0);
    add_step("other_addr", 0, 0, 1, 1, random_other_addr(), random_bits(32), 0);
    add_step("log_w0", 0, 0, 1, 1, LogAddr, random_bits(32), 0);
    add_step("log_w1", 0, 0, 1, 1, LogAddr, random_bits(32), 0);
    add_step("log_pop0", 0, 0, 0, 0, '0, '0, 1);
    add_step("log_pop1", 0, 0, 0, 0, '0, '0, 1);
    add_step("pop_empty", 0, 0, 0, 0, '0, '0, 1);
    add_step("passed", 0, 0, 1, 1, StatusAddr, sw_status_pkg::StatusPassed, 0);
    // Word still queued when the next reset arrives
    add_step("log_keep", 0, 0, 1, 1, LogAddr, random_bits(32), 0);
    add_step("after_pass", 0, 0, 1, 1, StatusAddr, sw_status_pkg::StatusFailed, 0);
    add_step("after_pass", 0, 0, 1, 1, StatusAddr, sw_status_pkg::StatusInTest, 0);
    add_step("fail_boot", 1, 0, 1, 1, StatusAddr, sw_status_pkg::StatusInBootRom, 0);
    add_step("failed", 0, 0, 1, 1, StatusAddr, sw_status_pkg::StatusFailed, 0);
    add_step("after_fail", 0, 0, 1, 1, StatusAddr, sw_status_pkg::StatusPassed, 0);
    add_step("stub_status", 1, 1, 1, 1, StatusAddr, sw_status_pkg::StatusInTest, 0);
    add_step("stub_log", 0, 1, 1, 1, LogAddr, random_bits(32), 0);
    add_step("stub_idle", 0, 1, 0, 0, '0, '0, 0);
    add_step("stub_off", 0, 0, 0, 0, '0, '0, 0);
    repeat (LogDepth + 1) begin
      add_step("ovf_write", 0, 0, 1, 1, LogAddr, random_bits(32), 0);
    end
    add_step("full_write", 0, 0, 1, 1, LogAddr, random_bits(32), 0);
    add_step("full_pop", 0, 0, 0, 0, '0, '0, 1);
    repeat (LogDepth) begin
      add_step("drain_pop", 0, 0, 0, 0, '0, '0, 1);
    end
    add_step("drain_empty", 0, 0, 0, 0, '0, '0, 1);
  endtask

  task automatic drive_idle(input logic [NameW-1:0] name);
    stub_cpu = 1'b0;
    req      = 1'b0;
    wr       = 1'b0;
    addr     = '0;
    wdata    = '0;
    log_pop  = 1'b0;
    cur_name = name;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    drive_idle("reset");
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic drive_step(input step_t s);
    stub_cpu = s.stub;
    req      = s.req;
    wr       = s.wr;
    addr     = ram_bus_pkg::ram_word_addr_t'(s.addr >> 2);
    wdata    = s.data;
    log_pop  = s.pop;
    cur_name = s.name;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit from the table length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    apply_reset();
    build_table();
    cycle_limit = steps.size() + 20;
    foreach (steps[i]) begin
      if (steps[i].rst) begin
        apply_reset();
      end
      drive_step(steps[i]);
      @(negedge clk);
    end
    drive_idle("tail");
    repeat (3) @(negedge clk);
    total_errors = error_count + u_sw_status_monitor.u_checker.fail_count;
    $display("Run complete after %0d steps, %0d scoreboard errors, %0d assertion failures",
             steps.size(), error_count, u_sw_status_monitor.u_checker.fail_count);
    if (total_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- sources.f
hdl/ram_bus_pkg.sv
hdl/sw_status_pkg.sv
hdl/ram_write_snoop.sv
hdl/test_status_decoder.sv
hdl/sw_log_fifo.sv
hdl/sw_status_monitor.sv
sim/sw_status_monitor_checker.sv
sim/sw_status_scoreboard.sv
sim/sw_status_monitor_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the status monitor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module sw_status_monitor_tb -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation failed"
  exit 1
fi

if ! grep -q "NO ERRORS" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi

echo "Simulation passed"
